/* source/ob_book_pkg.sv */
// Book-side types for the order book: price, quantity, uid, resting entry and ranking
package ob_book_pkg;

  // Limit price in ticks
  typedef logic [15:0] price_t;

  typedef logic [11:0] quantity_t;

  typedef logic [7:0] uid_t;

  // One resting order as held in a side table
  typedef struct packed {
    uid_t      uid;
    price_t    price;
    quantity_t quantity;
  } entry_t;

  // True when price a outranks price b on the given side
  // Bids rank high to low, asks rank low to high
  function automatic logic is_better(input logic is_ask, input price_t a, input price_t b);
    if (is_ask) begin
      return a < b;
    end
    return a > b;
  endfunction

endpackage

/* source/ob_msg_pkg.sv */
// Command and response message formats exchanged with the order book host
package ob_msg_pkg;

  import ob_book_pkg::*;

  typedef enum logic [1:0] {
    CMD_NOP    = 2'd0,
    CMD_BUY    = 2'd1,
    CMD_SELL   = 2'd2,
    CMD_CANCEL = 2'd3
  } cmd_op_t;

  // Cancel body carries only the uid
  typedef struct packed {
    uid_t        uid;
    logic [27:0] rsvd;
  } cmd_cancel_t;

  // Same 36 bits, read by opcode
  typedef union packed {
    entry_t      order;
    cmd_cancel_t cancel;
  } cmd_t;

  // Ingress word
  typedef struct packed {
    cmd_op_t op;
    cmd_t    body;
  } cmd_word_t;

  typedef enum logic [2:0] {
    RSP_ACCEPT      = 3'd0,
    RSP_REJECT      = 3'd1,
    RSP_CANCEL_HIT  = 3'd2,
    RSP_CANCEL_MISS = 3'd3,
    RSP_TRADE       = 3'd4
  } rsp_op_t;

  // Egress word, uid is the bid side for trades
  typedef struct packed {
    rsp_op_t   op;
    uid_t      uid;
    uid_t      uid_ask;
    price_t    price;
    quantity_t quantity;
  } rsp_t;

endpackage

/* source/ob_table_if.sv */
// Request and status bundle between the matching controller and one side table
`timescale 1ns/1ps

interface ob_table_if import ob_book_pkg::*; ();

  // Table status
  logic      head_vld;
  entry_t    head;
  logic      full;
  logic      cancel_hit;
  entry_t    cancel_entry;

  // Controller requests, one per cycle at most
  logic      insert;
  entry_t    insert_entry;
  logic      head_pop;
  logic      head_upt;
  quantity_t head_qty;
  logic      cancel;
  uid_t      cancel_uid;

  modport tbl (
    output head_vld, head, full, cancel_hit, cancel_entry,
    input  insert, insert_entry, head_pop, head_upt, head_qty, cancel, cancel_uid
  );

  modport cntrl (
    input  head_vld, head, full, cancel_hit, cancel_entry,
    output insert, insert_entry, head_pop, head_upt, head_qty, cancel, cancel_uid
  );

endinterface

/* source/ob_queue.sv */
// Circular FIFO with registered empty and full flags
`timescale 1ns/1ps

module ob_queue #(
  parameter int W = 8,
  parameter int N = 4
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         push,
  input  logic [W-1:0] push_data,
  input  logic         pop,
  output logic [W-1:0] pop_data,
  output logic         empty,
  output logic         full
);

  localparam int AW = (N > 1) ? $clog2(N) : 1;
  localparam int CW = $clog2(N + 1);

  logic [W-1:0]  mem [N];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic [CW-1:0] count_nxt;
  logic          do_push;
  logic          do_pop;

  // Push while full is dropped, pop while empty does nothing
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  always_comb begin
    count_nxt = count;
    case ({do_push, do_pop})
      2'b10:   count_nxt = count + 1'b1;
      2'b01:   count_nxt = count - 1'b1;
      default: count_nxt = count;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      empty  <= 1'b1;
      full   <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(N - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(N - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count_nxt;
      empty <= (count_nxt == '0);
      full  <= (count_nxt == CW'(N));
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  assign pop_data = mem[rd_ptr];

endmodule

/* source/ob_table.sv */
// Price-time sorted table of resting orders for one side of the book
`timescale 1ns/1ps

module ob_table import ob_book_pkg::*; #(
  parameter int N      = 4,
  parameter bit IS_ASK = 1'b0
) (
  input  logic       clk,
  input  logic       rst_n,
  ob_table_if.tbl    tbl
);

  entry_t       slot      [N];
  entry_t       slot_nxt  [N];
  entry_t       above     [N];
  entry_t       below     [N];
  logic [N-1:0] vld;
  logic [N-1:0] vld_nxt;
  logic [N-1:0] vld_up;
  logic [N-1:0] vld_dn;
  logic [N-1:0] beat;
  logic [N-1:0] beat_prev;
  logic [N-1:0] ins_first;
  logic [N-1:0] hit;
  logic [N-1:0] gone;
  logic [N-1:0] shift;
  logic         seen;

  // Neighbour views used by the shifts
  assign vld_up    = vld << 1;
  assign vld_dn    = vld >> 1;
  assign beat_prev = beat << 1;
  assign ins_first = beat & ~beat_prev;

  always_comb begin
    above[0] = tbl.insert_entry;
    for (int i = 1; i < N; i++) begin
      above[i] = slot[i-1];
    end
    for (int i = 0; i < N - 1; i++) begin
      below[i] = slot[i+1];
    end
    below[N-1] = '0;
  end

  // New entry lands ahead of the first slot it strictly outranks
  // Equal prices stay behind, which keeps arrival order
  always_comb begin
    for (int i = 0; i < N; i++) begin
      beat[i] = ~vld[i] | is_better(IS_ASK, tbl.insert_entry.price, slot[i].price);
    end
  end

  // Cancel lookup, only the first uid match is removed
  always_comb begin
    seen             = 1'b0;
    tbl.cancel_entry = '0;
    for (int i = 0; i < N; i++) begin
      hit[i] = vld[i] & (slot[i].uid == tbl.cancel_uid);
      if (hit[i] && !seen) begin
        tbl.cancel_entry = slot[i];
      end
      seen    = seen | hit[i];
      gone[i] = seen;
    end
    tbl.cancel_hit = tbl.cancel & seen;
  end

  // Pop moves every slot up, a cancel only those from the hit onwards
  always_comb begin
    if (tbl.head_pop) begin
      shift = '1;
    end else if (tbl.cancel) begin
      shift = gone;
    end else begin
      shift = '0;
    end
  end

  always_comb begin
    for (int i = 0; i < N; i++) begin
      slot_nxt[i] = slot[i];
      vld_nxt[i]  = vld[i];
      if (tbl.insert && ins_first[i]) begin
        slot_nxt[i] = tbl.insert_entry;
        vld_nxt[i]  = 1'b1;
      end else if (tbl.insert && beat[i]) begin
        slot_nxt[i] = above[i];
        vld_nxt[i]  = vld_up[i];
      end else if (shift[i]) begin
        slot_nxt[i] = below[i];
        vld_nxt[i]  = vld_dn[i];
      end
    end
    // Partial fill leaves the remainder in place
    if (tbl.head_upt) begin
      slot_nxt[0].quantity = tbl.head_qty;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld <= '0;
    end else begin
      vld <= vld_nxt;
    end
  end

  always_ff @(posedge clk) begin
    slot <= slot_nxt;
  end

  assign tbl.head_vld = vld[0];
  assign tbl.head     = slot[0];
  assign tbl.full     = vld[N-1];

endmodule

/* source/ob_cntrl.sv */
// Command decoder and matching engine driving both side tables and the response stream
`timescale 1ns/1ps

module ob_cntrl import ob_book_pkg::*; import ob_msg_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cmd_vld,
  input  cmd_word_t  cmd_word,
  output logic       cmd_pop,
  input  logic       rsp_full,
  output logic       rsp_push,
  output rsp_t       rsp_word,
  ob_table_if.cntrl  bid,
  ob_table_if.cntrl  ask
);

  logic      act_ok;
  logic      crossed;
  logic      side_full;
  quantity_t trade_qty;
  logic      push_nxt;
  rsp_t      rsp_nxt;

  // Nothing moves while the egress queue is full
  assign act_ok = ~rsp_full;

  // Bid at or above the ask
  assign crossed = bid.head_vld & ask.head_vld &
                   ~is_better(1'b0, ask.head.price, bid.head.price);

  assign trade_qty = (bid.head.quantity < ask.head.quantity) ?
                     bid.head.quantity : ask.head.quantity;

  assign side_full = (cmd_word.op == CMD_SELL) ? ask.full : bid.full;

  // Payload lines are steady, the strobes qualify them
  assign bid.insert_entry = cmd_word.body.order;
  assign ask.insert_entry = cmd_word.body.order;
  assign bid.cancel_uid   = cmd_word.body.cancel.uid;
  assign ask.cancel_uid   = cmd_word.body.cancel.uid;
  assign bid.head_qty     = bid.head.quantity - trade_qty;
  assign ask.head_qty     = ask.head.quantity - trade_qty;

  always_comb begin
    cmd_pop      = 1'b0;
    push_nxt     = 1'b0;
    rsp_nxt      = '0;
    bid.insert   = 1'b0;
    bid.head_pop = 1'b0;
    bid.head_upt = 1'b0;
    bid.cancel   = 1'b0;
    ask.insert   = 1'b0;
    ask.head_pop = 1'b0;
    ask.head_upt = 1'b0;
    ask.cancel   = 1'b0;

    if (act_ok && crossed) begin
      // Matching first, at the resting ask price
      push_nxt         = 1'b1;
      rsp_nxt.op       = RSP_TRADE;
      rsp_nxt.uid      = bid.head.uid;
      rsp_nxt.uid_ask  = ask.head.uid;
      rsp_nxt.price    = ask.head.price;
      rsp_nxt.quantity = trade_qty;
      // Smaller side leaves, both leave on equal quantity
      if (bid.head.quantity <= ask.head.quantity) begin
        bid.head_pop = 1'b1;
      end else begin
        bid.head_upt = 1'b1;
      end
      if (ask.head.quantity <= bid.head.quantity) begin
        ask.head_pop = 1'b1;
      end else begin
        ask.head_upt = 1'b1;
      end
    end else if (act_ok && cmd_vld) begin
      cmd_pop = 1'b1;
      case (cmd_word.op)
        CMD_BUY, CMD_SELL: begin
          push_nxt         = 1'b1;
          rsp_nxt.op       = side_full ? RSP_REJECT : RSP_ACCEPT;
          rsp_nxt.uid      = cmd_word.body.order.uid;
          rsp_nxt.price    = cmd_word.body.order.price;
          rsp_nxt.quantity = cmd_word.body.order.quantity;
          bid.insert       = ~side_full & (cmd_word.op == CMD_BUY);
          ask.insert       = ~side_full & (cmd_word.op == CMD_SELL);
        end
        CMD_CANCEL: begin
          // Uid may rest on either side, ask both
          push_nxt    = 1'b1;
          bid.cancel  = 1'b1;
          ask.cancel  = 1'b1;
          rsp_nxt.uid = cmd_word.body.cancel.uid;
          if (bid.cancel_hit) begin
            rsp_nxt.op       = RSP_CANCEL_HIT;
            rsp_nxt.price    = bid.cancel_entry.price;
            rsp_nxt.quantity = bid.cancel_entry.quantity;
          end else if (ask.cancel_hit) begin
            rsp_nxt.op       = RSP_CANCEL_HIT;
            rsp_nxt.price    = ask.cancel_entry.price;
            rsp_nxt.quantity = ask.cancel_entry.quantity;
          end else begin
            rsp_nxt.op = RSP_CANCEL_MISS;
          end
        end
        default: begin
          // NOP is consumed with no response
        end
      endcase
    end
  end

  // Output register holds its word until the egress queue has room
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_push <= 1'b0;
    end else if (act_ok) begin
      rsp_push <= push_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (act_ok) begin
      rsp_word <= rsp_nxt;
    end
  end

endmodule

/* source/ob.sv */
// Order book top level joining the command and response queues, side tables and controller
`timescale 1ns/1ps

module ob import ob_msg_pkg::*; #(
  parameter int BID_DEPTH   = 4,
  parameter int ASK_DEPTH   = 4,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cmd_vld,
  input  cmd_word_t cmd,
  output logic      cmd_full,
  input  logic      rsp_accept,
  output logic      rsp_vld,
  output rsp_t      rsp
);

  logic      ingress_empty;
  cmd_word_t ingress_data;
  logic      cntrl_cmd_vld;
  logic      cntrl_cmd_pop;
  logic      cntrl_rsp_push;
  rsp_t      cntrl_rsp_word;
  logic      egress_empty;
  logic      egress_full;
  logic      egress_pop;

  ob_table_if bid_if ();
  ob_table_if ask_if ();

  ob_queue #(.W($bits(cmd_word_t)), .N(QUEUE_DEPTH)) u_ingress (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (cmd_vld),
    .push_data (cmd),
    .pop       (cntrl_cmd_pop),
    .pop_data  (ingress_data),
    .empty     (ingress_empty),
    .full      (cmd_full)
  );

  assign cntrl_cmd_vld = ~ingress_empty;

  ob_table #(.N(BID_DEPTH), .IS_ASK(1'b0)) u_bid_table (
    .clk   (clk),
    .rst_n (rst_n),
    .tbl   (bid_if.tbl)
  );

  ob_table #(.N(ASK_DEPTH), .IS_ASK(1'b1)) u_ask_table (
    .clk   (clk),
    .rst_n (rst_n),
    .tbl   (ask_if.tbl)
  );

  ob_cntrl u_ob_cntrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_vld  (cntrl_cmd_vld),
    .cmd_word (ingress_data),
    .cmd_pop  (cntrl_cmd_pop),
    .rsp_full (egress_full),
    .rsp_push (cntrl_rsp_push),
    .rsp_word (cntrl_rsp_word),
    .bid      (bid_if.cntrl),
    .ask      (ask_if.cntrl)
  );

  // Host drains under its own accept strobe
  assign rsp_vld    = ~egress_empty;
  assign egress_pop = rsp_vld & rsp_accept;

  ob_queue #(.W($bits(rsp_t)), .N(QUEUE_DEPTH)) u_egress (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (cntrl_rsp_push),
    .push_data (cntrl_rsp_word),
    .pop       (egress_pop),
    .pop_data  (rsp),
    .empty     (egress_empty),
    .full      (egress_full)
  );

endmodule

/* test/ob_tb.sv */
// Order book testbench that drives a command table and checks the ordered response stream
`timescale 1ns/1ps

module ob_tb import ob_book_pkg::*; import ob_msg_pkg::*; ();

  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 16;
  localparam int N_CMD          = 17;
  localparam int N_RSP          = 23;
  localparam int NUM_PASSES     = 2;
  localparam int UID_STRIDE     = 32;
  localparam int IDLE_CYCLES    = 24;
  localparam int TIMEOUT_CYCLES = 200 * NUM_PASSES * (N_CMD + N_RSP);

  logic      clk;
  logic      rst_n;
  logic      cmd_vld;
  cmd_word_t cmd;
  logic      cmd_full;
  logic      rsp_accept;
  logic      rsp_vld;
  rsp_t      rsp;

  cmd_word_t   cmd_tbl [N_CMD];
  rsp_t        rsp_tbl [N_RSP];
  logic [31:0] lcg_state;

  ob dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_vld    (cmd_vld),
    .cmd        (cmd),
    .cmd_full   (cmd_full),
    .rsp_accept (rsp_accept),
    .rsp_vld    (rsp_vld),
    .rsp        (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic cmd_word_t order_cmd(input cmd_op_t op, input uid_t uid,
                                          input price_t price, input quantity_t qty);
    cmd_word_t w;
    w                     = '0;
    w.op                  = op;
    w.body.order.uid      = uid;
    w.body.order.price    = price;
    w.body.order.quantity = qty;
    return w;
  endfunction

  function automatic cmd_word_t cancel_cmd(input uid_t uid);
    cmd_word_t w;
    w                 = '0;
    w.op              = CMD_CANCEL;
    w.body.cancel.uid = uid;
    return w;
  endfunction

  function automatic rsp_t rsp_entry(input rsp_op_t op, input uid_t uid, input uid_t uid_ask,
                                     input price_t price, input quantity_t qty);
    rsp_t r;
    r.op       = op;
    r.uid      = uid;
    r.uid_ask  = uid_ask;
    r.price    = price;
    r.quantity = qty;
    return r;
  endfunction

  // Each pass uses its own uid range so uids never repeat
  function automatic cmd_word_t shift_cmd_uid(input cmd_word_t w, input int pass);
    cmd_word_t r;
    r = w;
    if (w.op == CMD_CANCEL) begin
      r.body.cancel.uid = uid_t'(w.body.cancel.uid + UID_STRIDE * pass);
    end else if (w.op != CMD_NOP) begin
      r.body.order.uid = uid_t'(w.body.order.uid + UID_STRIDE * pass);
    end
    return r;
  endfunction

  function automatic rsp_t shift_rsp_uid(input rsp_t e, input int pass);
    rsp_t r;
    r     = e;
    r.uid = uid_t'(e.uid + UID_STRIDE * pass);
    if (e.op == RSP_TRADE) begin
      r.uid_ask = uid_t'(e.uid_ask + UID_STRIDE * pass);
    end
    return r;
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TB FAILED");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_rsp(input rsp_t got, input rsp_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf({"mismatch at %0d ns: %s got op %0d uid %0d ask %0d px %0d qty %0d,",
                           " expected op %0d uid %0d ask %0d px %0d qty %0d"},
                          $time, what, got.op, got.uid, got.uid_ask, got.price, got.quantity,
                          exp.op, exp.uid, exp.uid_ask, exp.price, exp.quantity));
    end
  endtask

  task automatic check_full(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0d ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic load_tables();
    // Non-crossing buy and sell, then a crossing sell
    cmd_tbl[0]  = order_cmd(CMD_BUY, 8'd1, 16'd100, 12'd10);
    cmd_tbl[1]  = order_cmd(CMD_SELL, 8'd2, 16'd105, 12'd5);
    cmd_tbl[2]  = order_cmd(CMD_SELL, 8'd3, 16'd100, 12'd4);
    // Same price as the remainder of uid 1, so it queues behind it
    cmd_tbl[3]  = order_cmd(CMD_BUY, 8'd4, 16'd100, 12'd3);
    cmd_tbl[4]  = order_cmd(CMD_BUY, 8'd5, 16'd98, 12'd5);
    cmd_tbl[5]  = order_cmd(CMD_SELL, 8'd6, 16'd99, 12'd8);
    cmd_tbl[6]  = cancel_cmd(8'd4);
    cmd_tbl[7]  = cancel_cmd(8'd4);
    cmd_tbl[8]  = '0;
    // Fill the bid side so the fifth bid bounces
    cmd_tbl[9]  = order_cmd(CMD_BUY, 8'd7, 16'd97, 12'd1);
    cmd_tbl[10] = order_cmd(CMD_BUY, 8'd8, 16'd96, 12'd2);
    cmd_tbl[11] = order_cmd(CMD_BUY, 8'd9, 16'd95, 12'd3);
    cmd_tbl[12] = order_cmd(CMD_BUY, 8'd10, 16'd99, 12'd4);
    cmd_tbl[13] = cancel_cmd(8'd10);
    // Sweep every bid until an equal fill pops both heads
    cmd_tbl[14] = order_cmd(CMD_SELL, 8'd11, 16'd95, 12'd11);
    cmd_tbl[15] = cancel_cmd(8'd11);
    cmd_tbl[16] = cancel_cmd(8'd2);

    rsp_tbl[0]  = rsp_entry(RSP_ACCEPT, 8'd1, 8'd0, 16'd100, 12'd10);
    rsp_tbl[1]  = rsp_entry(RSP_ACCEPT, 8'd2, 8'd0, 16'd105, 12'd5);
    rsp_tbl[2]  = rsp_entry(RSP_ACCEPT, 8'd3, 8'd0, 16'd100, 12'd4);
    rsp_tbl[3]  = rsp_entry(RSP_TRADE, 8'd1, 8'd3, 16'd100, 12'd4);
    rsp_tbl[4]  = rsp_entry(RSP_ACCEPT, 8'd4, 8'd0, 16'd100, 12'd3);
    rsp_tbl[5]  = rsp_entry(RSP_ACCEPT, 8'd5, 8'd0, 16'd98, 12'd5);
    rsp_tbl[6]  = rsp_entry(RSP_ACCEPT, 8'd6, 8'd0, 16'd99, 12'd8);
    rsp_tbl[7]  = rsp_entry(RSP_TRADE, 8'd1, 8'd6, 16'd99, 12'd6);
    rsp_tbl[8]  = rsp_entry(RSP_TRADE, 8'd4, 8'd6, 16'd99, 12'd2);
    rsp_tbl[9]  = rsp_entry(RSP_CANCEL_HIT, 8'd4, 8'd0, 16'd100, 12'd1);
    rsp_tbl[10] = rsp_entry(RSP_CANCEL_MISS, 8'd4, 8'd0, 16'd0, 12'd0);
    rsp_tbl[11] = rsp_entry(RSP_ACCEPT, 8'd7, 8'd0, 16'd97, 12'd1);
    rsp_tbl[12] = rsp_entry(RSP_ACCEPT, 8'd8, 8'd0, 16'd96, 12'd2);
    rsp_tbl[13] = rsp_entry(RSP_ACCEPT, 8'd9, 8'd0, 16'd95, 12'd3);
    rsp_tbl[14] = rsp_entry(RSP_REJECT, 8'd10, 8'd0, 16'd99, 12'd4);
    rsp_tbl[15] = rsp_entry(RSP_CANCEL_MISS, 8'd10, 8'd0, 16'd0, 12'd0);
    rsp_tbl[16] = rsp_entry(RSP_ACCEPT, 8'd11, 8'd0, 16'd95, 12'd11);
    rsp_tbl[17] = rsp_entry(RSP_TRADE, 8'd5, 8'd11, 16'd95, 12'd5);
    rsp_tbl[18] = rsp_entry(RSP_TRADE, 8'd7, 8'd11, 16'd95, 12'd1);
    rsp_tbl[19] = rsp_entry(RSP_TRADE, 8'd8, 8'd11, 16'd95, 12'd2);
    rsp_tbl[20] = rsp_entry(RSP_TRADE, 8'd9, 8'd11, 16'd95, 12'd3);
    rsp_tbl[21] = rsp_entry(RSP_CANCEL_MISS, 8'd11, 8'd0, 16'd0, 12'd0);
    rsp_tbl[22] = rsp_entry(RSP_CANCEL_HIT, 8'd2, 8'd0, 16'd105, 12'd5);
  endtask

  // Push one command per falling edge unless the ingress queue is full
  task automatic drive_cmds(input int pass);
    int i;
    i = 0;
    while (i < N_CMD) begin
      @(negedge clk);
      if (cmd_full) begin
        cmd_vld = 1'b0;
      end else begin
        cmd     = shift_cmd_uid(cmd_tbl[i], pass);
        cmd_vld = 1'b1;
        i++;
      end
    end
    @(negedge clk);
    cmd_vld = 1'b0;
    cmd     = '0;
  endtask

  // Word seen at the falling edge is the one popped at the next rising edge
  task automatic collect_rsps(input int pass);
    int   idx;
    logic take;
    idx = 0;
    while (idx < N_RSP) begin
      @(negedge clk);
      lcg_state  = lcg_next(lcg_state);
      take       = (pass == 0) ? 1'b1 : (lcg_state[31:29] < 3'd3);
      rsp_accept = take;
      if (take && rsp_vld) begin
        check_rsp(rsp, shift_rsp_uid(rsp_tbl[idx], pass),
                  $sformatf("pass %0d response %0d", pass, idx));
        idx++;
      end
    end
  endtask

  // Nothing extra may follow the last expected response
  task automatic check_idle();
    repeat (IDLE_CYCLES) begin
      @(negedge clk);
      rsp_accept = 1'b1;
      check_full(rsp_vld, 1'b0, "rsp_vld once drained");
      check_full(cmd_full, 1'b0, "cmd_full once drained");
    end
  endtask

  initial begin : main
    cmd_vld    = 1'b0;
    cmd        = '0;
    rsp_accept = 1'b0;
    rst_n      = 1'b0;
    lcg_state  = 32'hcc73;
    load_tables();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_full(rsp_vld, 1'b0, "rsp_vld after reset");
    check_full(cmd_full, 1'b0, "cmd_full after reset");
    // First pass drains freely and the second runs under random back-pressure
    for (int pass = 0; pass < NUM_PASSES; pass++) begin
      fork
        drive_cmds(pass);
        collect_rsps(pass);
      join
      check_idle();
    end
    $display("TB PASSED");
    $finish;
  end

  initial begin : watchdog
    repeat (RESET_CYCLES + TIMEOUT_CYCLES) @(posedge clk);
    abort_run($sformatf("timeout: responses still missing after %0d cycles",
                        RESET_CYCLES + TIMEOUT_CYCLES));
  end

endmodule

/* vlog.f */
source/ob_book_pkg.sv
source/ob_msg_pkg.sv
source/ob_table_if.sv
source/ob_queue.sv
source/ob_table.sv
source/ob_cntrl.sv
source/ob.sv
test/ob_tb.sv

/* Bender.yml */
package:
  name: ob

sources:
  - files:
      - source/ob_book_pkg.sv
      - source/ob_msg_pkg.sv
      - source/ob_table_if.sv
      - source/ob_queue.sv
      - source/ob_table.sv
      - source/ob_cntrl.sv
      - source/ob.sv
  - target: test
    files:
      - test/ob_tb.sv
